// File: files.f
source/board_pkg.sv
source/piece_pkg.sv
source/piece_fit.sv
source/board_store.sv
source/game_control.sv
source/tetris_top.sv
verification/tetris_props.sv
verification/tetris_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" &&
rm -rf obj_dir &&
verilator --binary --timing --assert -Wno-fatal --top-module tetris_tb \
	-f files.f -o tetris_sim > build.log 2>&1 &&
./obj_dir/tetris_sim > sim.log 2>&1 ||
{ echo "Build or simulation aborted, see build.log and sim.log"; exit 1; }
grep -q "Result: PASSED" sim.log && echo "Simulation passed" ||
{ echo "Simulation failed, see sim.log"; exit 1; }

// File: source/board_pkg.sv
package board_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Board geometry
	////////////////////////////////////////////////////////////////////////////

	// Width in cells
	localparam int BOARD_COLS = 8;

	// Height in cells, row 0 is the floor
	localparam int BOARD_ROWS = 20;

	localparam int BOARD_CELLS = BOARD_COLS * BOARD_ROWS;

	// Anchor of a new piece, row 19 column 2
	localparam int SPAWN_CELL = 154;

	// Cell number is row * 8 + column
	typedef logic [7:0] cell_idx_t;

	// One board row, bit n is column n
	typedef logic [BOARD_COLS-1:0] row_t;

	////////////////////////////////////////////////////////////////////////////
	// Board word
	////////////////////////////////////////////////////////////////////////////

	// Flat view for painting and fit checks, row view for full row scans
	typedef union packed {
		logic [BOARD_CELLS-1:0] cells;
		row_t [BOARD_ROWS-1:0] rows;
	} board_u;

endpackage

// File: source/board_store.sv
`timescale 1ns/10ps

module board_store (
	input logic Clk,
	input logic Reset,
	input logic spawn,
	input piece_pkg::piece_kind_e spawn_kind,
	input logic step,
	input piece_pkg::piece_t old_piece,
	input piece_pkg::piece_t new_piece,
	input logic clear,
	input logic wipe,
	output board_pkg::board_u board,
	output logic any_full,
	output logic spawn_blocked
);
	import board_pkg::*;
	import piece_pkg::*;

	logic [BOARD_ROWS-1:0] full_rows;
	logic [4:0] low_row;
	board_u compacted;
	board_u spawn_mask;
	board_u old_mask;
	board_u new_mask;
	board_u step_next;

	////////////////////////////////////////////////////////////////////////////
	// Full row scan and compaction
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		for (int r = 0; r < BOARD_ROWS; r++)
		begin
			full_rows[r] = &board.rows[r];
		end
	end

	assign any_full = |full_rows;

	// Lowest full row goes first
	always_comb
	begin
		low_row = '0;
		for (int r = BOARD_ROWS - 1; r >= 0; r--)
		begin
			if (full_rows[r])
				low_row = 5'(r);
		end
	end

	// Rows from low_row upward drop by one, empty row enters at the top
	always_comb
	begin
		for (int r = 0; r < BOARD_ROWS - 1; r++)
		begin
			if (5'(r) < low_row)
				compacted.rows[r] = board.rows[r];
			else
				compacted.rows[r] = board.rows[r + 1];
		end
		compacted.rows[BOARD_ROWS - 1] = '0;
	end

	////////////////////////////////////////////////////////////////////////////
	// Piece paint
	////////////////////////////////////////////////////////////////////////////

	// New pieces always start flat at the spawn anchor
	assign spawn_mask = shape_mask(spawn_kind, ORIENT_FLAT, SPAWN_CELL / BOARD_COLS,
		SPAWN_CELL % BOARD_COLS);

	assign spawn_blocked = |(board.cells & spawn_mask.cells);

	assign old_mask = piece_mask(old_piece);
	assign new_mask = piece_mask(new_piece);

	// Erase first, then paint, so overlapping cells stay set
	assign step_next.cells = (board.cells & ~old_mask.cells) | new_mask.cells;

	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
			board <= '0;
		else if (wipe)
			board <= '0;
		else if (clear)
			board <= compacted;
		else if (spawn)
			board.cells <= board.cells | spawn_mask.cells;
		else if (step)
			board <= step_next;
	end

endmodule

// File: source/game_control.sv
`timescale 1ns/10ps

module game_control #(
	parameter int DROP_TICKS = 16
) (
	input logic Clk,
	input logic Reset,
	input logic start,
	input logic ack,
	input piece_pkg::move_cmd_t cmd,
	input piece_pkg::fit_t fit,
	input logic any_full,
	input logic spawn_blocked,
	output piece_pkg::game_status_t status,
	output piece_pkg::piece_t piece,
	output piece_pkg::piece_kind_e next_kind,
	output logic step,
	output piece_pkg::piece_t step_piece,
	output logic spawn,
	output logic clear,
	output logic wipe,
	output logic [7:0] score
);
	import board_pkg::*;
	import piece_pkg::*;

	localparam int TICK_W = $clog2(DROP_TICKS + 1);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_SPAWN,
		ST_PLAY,
		ST_LAND,
		ST_CLEAR,
		ST_LOSE
	} state_e;

	state_e state;
	state_e state_next;

	// Gravity
	logic [TICK_W-1:0] drop_cnt;
	logic gravity_due;
	logic go_down;
	logic land_now;

	// Piece sequence
	logic [7:0] lfsr;
	logic lfsr_fb;

	////////////////////////////////////////////////////////////////////////////
	// Move selection
	////////////////////////////////////////////////////////////////////////////

	assign gravity_due = (drop_cnt == TICK_W'(DROP_TICKS - 1));

	// Gravity wins, else left, right, down, rotate in that order
	always_comb
	begin
		step = 1'b0;
		step_piece = piece;
		go_down = 1'b0;
		land_now = 1'b0;
		if (state == ST_PLAY)
		begin
			if (!gravity_due && cmd.left && fit.can_left)
			begin
				step = 1'b1;
				step_piece.anchor = piece.anchor - 8'd1;
			end
			else if (!gravity_due && cmd.right && fit.can_right)
			begin
				step = 1'b1;
				step_piece.anchor = piece.anchor + 8'd1;
			end
			else if (gravity_due || cmd.down)
			begin
				go_down = 1'b1;
				if (fit.can_down)
				begin
					step = 1'b1;
					step_piece.anchor = piece.anchor - 8'(BOARD_COLS);
				end
				else
					land_now = 1'b1;
			end
			else if (cmd.rotate && fit.can_rotate)
			begin
				step = 1'b1;
				step_piece.orient = (piece.orient == ORIENT_FLAT) ? ORIENT_UPRIGHT : ORIENT_FLAT;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// State machine
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		state_next = state;
		case (state)
			ST_IDLE:
				if (start)
					state_next = ST_SPAWN;
			ST_SPAWN:
				state_next = spawn_blocked ? ST_LOSE : ST_PLAY;
			ST_PLAY:
				if (land_now)
					state_next = ST_LAND;
			ST_LAND:
				state_next = any_full ? ST_CLEAR : ST_SPAWN;
			ST_CLEAR:
				if (!any_full)
					state_next = ST_SPAWN;
			ST_LOSE:
				if (ack)
					state_next = ST_IDLE;
			default:
				state_next = ST_IDLE;
		endcase
	end

	assign spawn = (state == ST_SPAWN);
	assign clear = (state == ST_CLEAR) && any_full;
	assign wipe = (state == ST_LOSE) && ack;

	// Row clear reports as land so the flags stay one-hot
	assign status = '{
		idle: state == ST_IDLE,
		spawn: state == ST_SPAWN,
		play: state == ST_PLAY,
		land: (state == ST_LAND) || (state == ST_CLEAR),
		lose: state == ST_LOSE
	};

	// Taps 8 6 5 4
	assign lfsr_fb = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];
	assign next_kind = piece_kind_e'(lfsr[0]);

	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
		begin
			state <= ST_IDLE;
			drop_cnt <= '0;
			lfsr <= 8'h01;
			piece <= '{kind: PIECE_SQUARE, orient: ORIENT_FLAT, anchor: '0};
			score <= '0;
		end
		else
		begin
			state <= state_next;
			if (spawn)
			begin
				piece <= '{kind: next_kind, orient: ORIENT_FLAT, anchor: cell_idx_t'(SPAWN_CELL)};
				lfsr <= {lfsr[6:0], lfsr_fb};
			end
			else if (step)
				piece <= step_piece;
			// Counts play cycles since the last down
			if (state != ST_PLAY || go_down)
				drop_cnt <= '0;
			else
				drop_cnt <= drop_cnt + 1'b1;
			if (wipe)
				score <= '0;
			else if (clear)
				score <= score + 8'd1;
		end
	end

endmodule

// File: source/piece_fit.sv
`timescale 1ns/10ps

module piece_fit (
	input board_pkg::board_u board,
	input piece_pkg::piece_t piece,
	output piece_pkg::fit_t fit
);
	import board_pkg::*;
	import piece_pkg::*;

	int anchor_row;
	int anchor_col;
	orient_e turned;

	// Current shape and everything else on the board
	board_u own;
	board_u others;

	// Candidate shapes, one per command
	board_u left_mask;
	board_u right_mask;
	board_u down_mask;
	board_u turn_mask;

	// All four cells landed on the board and none hits another piece
	function automatic logic placeable(board_u target, board_u occupied);
		return ($countones(target.cells) == 4) && ((target.cells & occupied.cells) == '0);
	endfunction

	assign anchor_row = int'(piece.anchor) / BOARD_COLS;
	assign anchor_col = int'(piece.anchor) % BOARD_COLS;

	assign turned = (piece.orient == ORIENT_FLAT) ? ORIENT_UPRIGHT : ORIENT_FLAT;

	// The piece may move into cells it already covers
	assign own = piece_mask(piece);
	assign others.cells = board.cells & ~own.cells;

	// Column moves work on row and column, so a shape never wraps a side
	assign left_mask = shape_mask(piece.kind, piece.orient, anchor_row, anchor_col - 1);
	assign right_mask = shape_mask(piece.kind, piece.orient, anchor_row, anchor_col + 1);
	assign down_mask = shape_mask(piece.kind, piece.orient, anchor_row - 1, anchor_col);

	// Bar turns about its anchor
	assign turn_mask = shape_mask(piece.kind, turned, anchor_row, anchor_col);

	assign fit.can_left = placeable(left_mask, others);
	assign fit.can_right = placeable(right_mask, others);
	assign fit.can_down = placeable(down_mask, others);

	// Square has no second orientation
	assign fit.can_rotate = (piece.kind == PIECE_BAR) && placeable(turn_mask, others);

endmodule

// File: source/piece_pkg.sv
package piece_pkg;

	typedef enum logic {
		PIECE_SQUARE = 1'b0,
		PIECE_BAR = 1'b1
	} piece_kind_e;

	typedef enum logic {
		ORIENT_FLAT = 1'b0,
		ORIENT_UPRIGHT = 1'b1
	} orient_e;

	// Player buttons, sampled every cycle in play
	typedef struct packed {
		logic left;
		logic right;
		logic down;
		logic rotate;
	} move_cmd_t;

	// One-hot game state flags
	typedef struct packed {
		logic idle;
		logic spawn;
		logic play;
		logic land;
		logic lose;
	} game_status_t;

	typedef struct packed {
		logic can_left;
		logic can_right;
		logic can_down;
		logic can_rotate;
	} fit_t;

	typedef struct packed {
		piece_kind_e kind;
		orient_e orient;
		board_pkg::cell_idx_t anchor;
	} piece_t;

	////////////////////////////////////////////////////////////////////////////
	// Piece shapes
	////////////////////////////////////////////////////////////////////////////

	// Cells of a shape placed at row and col, cells off the board are dropped
	function automatic board_pkg::board_u shape_mask(piece_kind_e kind, orient_e orient,
		int row, int col);
		board_pkg::board_u mask;
		int dr [4];
		int dc [4];
		int r;
		int c;
		mask = '0;
		if (kind == PIECE_SQUARE)
		begin
			dr = '{0, 0, -1, -1};
			dc = '{0, -1, 0, -1};
		end
		else if (orient == ORIENT_FLAT)
		begin
			dr = '{0, 0, 0, 0};
			dc = '{1, 0, -1, -2};
		end
		else
		begin
			dr = '{1, 0, -1, -2};
			dc = '{0, 0, 0, 0};
		end
		for (int i = 0; i < 4; i++)
		begin
			r = row + dr[i];
			c = col + dc[i];
			if (r >= 0 && r < board_pkg::BOARD_ROWS && c >= 0 && c < board_pkg::BOARD_COLS)
				mask.rows[r][c] = 1'b1;
		end
		return mask;
	endfunction

	// Shape of a piece at its own anchor
	function automatic board_pkg::board_u piece_mask(piece_t p);
		return shape_mask(p.kind, p.orient, int'(p.anchor) / board_pkg::BOARD_COLS,
			int'(p.anchor) % board_pkg::BOARD_COLS);
	endfunction

endpackage

// File: source/tetris_top.sv
`timescale 1ns/10ps

module tetris_top #(
	parameter int DROP_TICKS = 16
) (
	input logic Clk,
	input logic Reset,
	input logic start,
	input logic ack,
	input piece_pkg::move_cmd_t cmd,
	output piece_pkg::game_status_t status,
	output board_pkg::board_u board,
	output logic [7:0] score,
	output piece_pkg::piece_t piece,
	output piece_pkg::piece_kind_e next_kind
);
	import piece_pkg::*;

	fit_t fit;
	piece_t step_piece;
	logic step;
	logic spawn;
	logic clear;
	logic wipe;
	logic any_full;
	logic spawn_blocked;

	game_control #(
		.DROP_TICKS(DROP_TICKS)
	) u_control (
		.Clk(Clk),
		.Reset(Reset),
		.start(start),
		.ack(ack),
		.cmd(cmd),
		.fit(fit),
		.any_full(any_full),
		.spawn_blocked(spawn_blocked),
		.status(status),
		.piece(piece),
		.next_kind(next_kind),
		.step(step),
		.step_piece(step_piece),
		.spawn(spawn),
		.clear(clear),
		.wipe(wipe),
		.score(score)
	);

	piece_fit u_fit (
		.board(board),
		.piece(piece),
		.fit(fit)
	);

	// Spawn paints the kind that control is about to load
	board_store u_board (
		.Clk(Clk),
		.Reset(Reset),
		.spawn(spawn),
		.spawn_kind(next_kind),
		.step(step),
		.old_piece(piece),
		.new_piece(step_piece),
		.clear(clear),
		.wipe(wipe),
		.board(board),
		.any_full(any_full),
		.spawn_blocked(spawn_blocked)
	);

endmodule

// File: verification/tetris_patterns.txt
# name  kind(0 square, 1 bar)  rotate(0 or 1)  direction(L or R)
# board(40 hex digits, row 19 first, bit n of a row is column n)  score
p1_bar_left 1 0 L 000000000000000000000000000000000000000F 0
p2_square_left 0 0 L 000000000000000000000000000000000003030F 0
p3_square_left 0 0 L 000000000000000000000000000000030303030F 0
p4_square_left 0 0 L 000000000000000000000000000303030303030F 0
p5_bar_right_fill 1 0 R 00000000000000000000000000030303030303FF 0
p6_bar_right_after_clear 1 0 R 00000000000000000000000000000303030303F3 1
p7_bar_upright_right 1 1 R 00000000000000000000000000000383838383F3 1

// File: verification/tetris_props.sv
`timescale 1ns/10ps

module tetris_props (
	input logic Clk,
	input logic Reset,
	input piece_pkg::game_status_t status,
	input logic [7:0] score,
	input piece_pkg::piece_t piece,
	input logic clear
);
	////////////////////////////////////////////////////////////////////////////
	// Control rules
	////////////////////////////////////////////////////////////////////////////

	status_onehot: assert property (@(posedge Clk) disable iff (Reset)
		$onehot(status))
		else $error("Status flags are not one-hot");

	// Score moves after a clear strobe, or back to zero on the way to idle
	score_moves: assert property (@(posedge Clk) disable iff (Reset)
		!$stable(score) |-> ($past(clear) || status.idle))
		else $error("Score changed outside row clear and idle");

	// A piece moves only when it spawns or takes a step in play
	piece_moves_in_play: assert property (@(posedge Clk) disable iff (Reset)
		$changed(piece) |-> $past(status.spawn || status.play))
		else $error("Piece changed outside spawn and play");

endmodule

bind game_control tetris_props u_props (
	.Clk(Clk),
	.Reset(Reset),
	.status(status),
	.score(score),
	.piece(piece),
	.clear(clear)
);

// File: verification/tetris_tb.sv
`timescale 1ns/10ps

module tetris_tb;
	import board_pkg::*;
	import piece_pkg::*;

	localparam int DROP_TICKS = 4;
	localparam int WAIT_LIMIT = 400;
	localparam int LOSE_LIMIT = 4000;

	localparam game_status_t IDLE_FLAG = '{idle: 1'b1, default: 1'b0};
	localparam game_status_t PLAY_FLAG = '{play: 1'b1, default: 1'b0};
	localparam game_status_t LAND_FLAG = '{land: 1'b1, default: 1'b0};
	localparam game_status_t LOSE_FLAG = '{lose: 1'b1, default: 1'b0};
	localparam game_status_t LAND_OR_LOSE = '{land: 1'b1, lose: 1'b1, default: 1'b0};
	localparam move_cmd_t NO_MOVE = '{default: 1'b0};
	localparam move_cmd_t MOVE_LEFT = '{left: 1'b1, default: 1'b0};
	localparam move_cmd_t MOVE_RIGHT = '{right: 1'b1, default: 1'b0};
	localparam move_cmd_t MOVE_DOWN = '{down: 1'b1, default: 1'b0};
	localparam move_cmd_t MOVE_TURN = '{rotate: 1'b1, default: 1'b0};

	logic Clk;
	logic Reset;
	logic start;
	logic ack;
	move_cmd_t cmd;
	game_status_t status;
	board_u board;
	logic [7:0] score;
	piece_t piece;
	piece_kind_e next_kind;

	// Reference piece sequence
	logic [7:0] lfsr_model;

	// Board and score once the last landing has settled
	board_u settled;
	logic [7:0] settled_score;

	tetris_top #(
		.DROP_TICKS(DROP_TICKS)
	) u_dut (
		.Clk(Clk),
		.Reset(Reset),
		.start(start),
		.ack(ack),
		.cmd(cmd),
		.status(status),
		.board(board),
		.score(score),
		.piece(piece),
		.next_kind(next_kind)
	);

	always #20 Clk = ~Clk;

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	task automatic stop_with_error(input string what);
		$display("%s", what);
		$display("Result: FAILED");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic compare_board(input string name, input board_u exp, input board_u act);
		if (act !== exp)
			stop_with_error($sformatf("[FAIL] %s board expected %h actual %h", name, exp, act));
	endtask

	task automatic compare_score(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp)
			stop_with_error($sformatf("[FAIL] %s score expected %0d actual %0d", name, exp, act));
	endtask

	task automatic compare_kind(input string name, input piece_kind_e exp, input piece_kind_e act);
		if (act !== exp)
			stop_with_error($sformatf("[FAIL] %s kind expected %0d actual %0d", name, exp, act));
	endtask

	task automatic compare_status(input string name, input game_status_t exp,
		input game_status_t act);
		if (act !== exp)
			stop_with_error($sformatf("[FAIL] %s status expected %b actual %b", name, exp, act));
	endtask

	task automatic compare_piece(input string name, input piece_t exp, input piece_t act);
		if (act !== exp)
			stop_with_error($sformatf("[FAIL] %s piece expected %h actual %h", name, exp, act));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////////////////////

	// Polls on falling edges until a flag in mask is high
	task automatic wait_for_flag(input string name, input game_status_t mask, input int limit);
		int n;
		n = 0;
		while ((status & mask) == '0)
		begin
			@(negedge Clk);
			n++;
			if (n > limit)
				stop_with_error($sformatf("Timed out in %s waiting for status %b", name, mask));
		end
	endtask

	// One command for exactly one clock edge
	task automatic press(input move_cmd_t c);
		cmd = c;
		@(negedge Clk);
	endtask

	// Cells of a new flat piece at the spawn anchor
	function automatic board_u spawn_shape(input piece_kind_e kind);
		board_u m;
		m = '0;
		m.cells[SPAWN_CELL] = 1'b1;
		m.cells[SPAWN_CELL - 1] = 1'b1;
		if (kind == PIECE_SQUARE)
		begin
			m.cells[SPAWN_CELL - 8] = 1'b1;
			m.cells[SPAWN_CELL - 9] = 1'b1;
		end
		else
		begin
			m.cells[SPAWN_CELL + 1] = 1'b1;
			m.cells[SPAWN_CELL - 2] = 1'b1;
		end
		return m;
	endfunction

	// Keeps the rows that are not full, packed down from the floor
	function automatic board_u drop_full_rows(input board_u b, output int removed);
		board_u kept;
		int k;
		kept = '0;
		k = 0;
		removed = 0;
		for (int r = 0; r < BOARD_ROWS; r++)
		begin
			if (b.rows[r] == '1)
				removed++;
			else
			begin
				kept.rows[k] = b.rows[r];
				k++;
			end
		end
		return kept;
	endfunction

	task automatic play_pattern(input string name, input piece_kind_e kind, input int turn,
		input string dir, input board_u exp_board, input logic [7:0] exp_score);
		board_u shape;
		board_u with_spawn;
		piece_t upright;
		move_cmd_t hold;
		int removed;
		wait_for_flag(name, PLAY_FLAG, WAIT_LIMIT);
		compare_kind({name, " sequence"}, piece_kind_e'(lfsr_model[0]), piece.kind);
		compare_kind(name, kind, piece.kind);
		lfsr_model = {lfsr_model[6:0], lfsr_model[7] ^ lfsr_model[5] ^ lfsr_model[4] ^
			lfsr_model[3]};
		compare_kind({name, " next"}, piece_kind_e'(lfsr_model[0]), next_kind);
		shape = spawn_shape(kind);
		with_spawn.cells = settled.cells | shape.cells;
		compare_board({name, " spawn"}, with_spawn, board);
		compare_score({name, " spawn"}, settled_score, score);
		if (turn != 0)
		begin
			// Room to turn, then to the left wall and one column back
			press(MOVE_DOWN);
			press(MOVE_TURN);
			press(MOVE_DOWN);
			press(MOVE_LEFT);
			press(MOVE_LEFT);
			press(MOVE_RIGHT);
			upright = '{kind: PIECE_BAR, orient: ORIENT_UPRIGHT, anchor: 8'(17 * 8 + 1)};
			compare_piece({name, " upright"}, upright, piece);
		end
		hold = (dir == "L") ? MOVE_LEFT : MOVE_RIGHT;
		hold.down = 1'b1;
		cmd = hold;
		wait_for_flag(name, LAND_OR_LOSE, WAIT_LIMIT);
		cmd = NO_MOVE;
		compare_status({name, " land"}, LAND_FLAG, status);
		compare_board(name, exp_board, board);
		compare_score(name, exp_score, score);
		// Full rows leave before the next spawn, one point each
		settled = drop_full_rows(exp_board, removed);
		settled_score = exp_score + 8'(removed);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		int fd;
		int items;
		int count;
		int gap;
		int kind_val;
		int turn;
		int score_val;
		string line;
		string name;
		string dir;
		logic [BOARD_CELLS-1:0] bits;
		board_u exp_board;
		Clk = 1'b0;
		Reset = 1'b1;
		start = 1'b0;
		ack = 1'b0;
		cmd = NO_MOVE;
		lfsr_model = 8'h01;
		settled = '0;
		settled_score = 8'd0;
		count = 0;
		void'($urandom(32'h651a6c8b));
		repeat (10) @(negedge Clk);
		Reset = 1'b0;
		@(negedge Clk);
		compare_status("reset", IDLE_FLAG, status);
		compare_board("reset", '0, board);
		compare_score("reset", 8'd0, score);
		start = 1'b1;
		@(negedge Clk);
		start = 1'b0;

		fd = $fopen("verification/tetris_patterns.txt", "r");
		if (fd == 0)
			stop_with_error("Could not open the pattern file");
		while (!$feof(fd))
		begin
			line = "";
			if ($fgets(line, fd) == 0)
				break;
			if (line.len() < 2 || line[0] == "#")
				continue;
			items = $sscanf(line, "%s %d %d %s %h %d", name, kind_val, turn, dir, bits,
				score_val);
			if (items != 6)
				stop_with_error($sformatf("Pattern line could not be read: %s", line));
			exp_board.cells = bits;
			play_pattern(name, piece_kind_e'(kind_val), turn, dir, exp_board, 8'(score_val));
			count++;
			gap = $urandom_range(3, 0);
			repeat (gap) @(negedge Clk);
		end
		$fclose(fd);
		if (count == 0)
			stop_with_error("The pattern file holds no patterns");

		// Straight drops pile up until the spawn area is taken
		cmd = MOVE_DOWN;
		wait_for_flag("stack_to_lose", LOSE_FLAG, LOSE_LIMIT);
		cmd = NO_MOVE;
		// No row fills while stacking
		compare_score("stack_to_lose", settled_score, score);
		ack = 1'b1;
		@(negedge Clk);
		ack = 1'b0;
		compare_status("ack_to_idle", IDLE_FLAG, status);
		compare_board("ack_to_idle", '0, board);
		compare_score("ack_to_idle", 8'd0, score);

		$display("Result: PASSED");
		$finish;
	end

endmodule
